// File: design/fhp_data_framer.sv
`timescale 1ns/1ps
// fhp data framer
// forwards data beats to the analyzer and reports the frame byte count at end of frame.
module fhp_data_framer (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  beat_valid,
   input  fhp_pkg::tlv_data_t    beat_data,
   input  fhp_pkg::tlv_strb_t    beat_strb,
   input  logic                  beat_eot,
   input  logic                  data_beat,
   input  logic                  first_data_beat,
   output logic                  dp_valid,
   output fhp_pkg::tlv_data_t    dp_data,
   output logic                  dp_sof,
   output logic                  dp_eof,
   output fhp_pkg::bytes_valid_t dp_bytes_valid,
   output fhp_pkg::frm_bytes_t   eof_frm_bytes
);

   fhp_pkg::frm_bytes_t   frm_sum;       // bytes of the frame so far.
   fhp_pkg::frm_bytes_t   last_bytes;
   fhp_pkg::bytes_valid_t bytes_valid;
   logic                  fwd;

   // strobes are contiguous from byte 0, so the count of ones is the length.
   function automatic fhp_pkg::bytes_valid_t strb_to_bytes_valid(
      input fhp_pkg::tlv_strb_t strb
   );
      logic [3:0] ones;
      int         i;
      ones = '0;
      for (i = 0; i < $bits(strb); i++) begin
         ones = ones + {3'b000, strb[i]};
      end
      return ones[2:0];  // a full strobe wraps to zero.
   endfunction

   assign fwd         = beat_valid && data_beat;
   assign bytes_valid = strb_to_bytes_valid(beat_strb);
   assign last_bytes  = (bytes_valid == '0) ? fhp_pkg::frm_bytes_t'(fhp_pkg::beat_bytes) :
                        fhp_pkg::frm_bytes_t'(bytes_valid);

   // ****************************************
   // output stage
   // ****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_valid       <= 1'b0;
         dp_sof         <= 1'b0;
         dp_eof         <= 1'b0;
         dp_bytes_valid <= '0;
         eof_frm_bytes  <= '0;
         frm_sum        <= '0;
      end else begin
         dp_valid       <= fwd;
         dp_sof         <= fwd && first_data_beat;
         dp_eof         <= fwd && beat_eot;
         dp_bytes_valid <= fwd ? bytes_valid : '0;
         eof_frm_bytes  <= '0;
         if (fwd) begin
            if (beat_eot) begin
               eof_frm_bytes <= frm_sum + last_bytes;
               frm_sum       <= '0;
            end else begin
               frm_sum <= frm_sum + fhp_pkg::frm_bytes_t'(fhp_pkg::beat_bytes);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fwd) begin
         dp_data <= beat_data;
      end
   end

   a_eof_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
      dp_eof |-> dp_valid);

endmodule

// File: design/fhp_pkg.sv
// frame header parser shared definitions.
// holds the widths, TLV and state encodings, error codes and format identifiers.
package fhp_pkg;

   // ****************************************
   // widths
   // ****************************************
   typedef logic [63:0] tlv_data_t;
   typedef logic [7:0]  tlv_strb_t;
   typedef logic [2:0]  bytes_valid_t;    // zero means a full beat.
   typedef logic [27:0] frm_bytes_t;
   typedef logic [10:0] frame_num_t;

   // ****************************************
   // encodings
   // ****************************************
   typedef enum logic [4:0] {
      tlv_frmd_int_app = 5'd2,
      tlv_frmd_int_sip = 5'd3,
      tlv_data_unk     = 5'd8,
      tlv_data         = 5'd9,
      tlv_other        = 5'd31
   } tlv_type_e;

   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_frmd = 2'd1,
      st_data = 2'd2,
      st_skip = 2'd3
   } seq_state_e;

   typedef enum logic [1:0] {
      coding_parseable = 2'd0,
      coding_raw       = 2'd1
   } frm_coding_e;

   typedef enum logic [2:0] {
      fmt_none = 3'd0,
      fmt_xp9  = 3'd1,
      fmt_xp10 = 3'd2,
      fmt_gzip = 3'd3,
      fmt_zlib = 3'd4
   } sof_fmt_e;

   typedef enum logic [1:0] {
      err_no_errors       = 2'd0,
      err_bad_format      = 2'd1,
      err_pfx_data_absent = 2'd2
   } fhp_error_e;

   // ****************************************
   // constants
   // ****************************************
   localparam logic [31:0] xp9_id            = 32'h3958_5046;  // low word of an xp9 frame.
   localparam logic [31:0] xp10_id           = 32'h3031_5846;
   localparam logic [7:0]  gzip_id1          = 8'h1f;
   localparam logic [7:0]  gzip_id2          = 8'h8b;
   localparam logic [3:0]  zlib_cm           = 4'd8;          // deflate method.
   localparam int          coding_lsb        = 16;
   localparam logic [3:0]  frmd_app_loc      = 4'd3;
   localparam logic [3:0]  frmd_sip_loc      = 4'd1;
   localparam int          hdr_frame_num_lsb = 16;
   localparam int          xp10_pfx_lo_lsb   = 36;
   localparam int          xp10_pfx_lo_msb   = 37;
   localparam int          xp10_pfx_hi_lsb   = 38;
   localparam int          xp10_pfx_hi_msb   = 43;
   localparam int          beat_bytes        = 8;

endpackage

// File: design/fhp_sof_classifier.sv
`timescale 1ns/1ps
// fhp start-of-frame classifier
// classifies the first data beat of a frame and pulses one statistics strobe.
module fhp_sof_classifier (
   input  logic                 clk,
   input  logic                 rst_n,
   input  fhp_pkg::tlv_data_t   beat_data,
   input  logic                 first_data_beat,
   input  fhp_pkg::frm_coding_e frm_coding,
   input  fhp_pkg::frame_num_t  frame_num,
   output logic                 sof_valid,
   output fhp_pkg::sof_fmt_e    sof_fmt,
   output fhp_pkg::fhp_error_e  sof_error,
   output fhp_pkg::frame_num_t  sof_frame_num,
   output logic                 xp9_frm_stb,
   output logic                 xp10_frm_stb,
   output logic                 raw_frm_stb,
   output logic                 gzip_frm_stb,
   output logic                 zlib_frm_stb
);

   fhp_pkg::sof_fmt_e   fmt_nxt;
   fhp_pkg::fhp_error_e err_nxt;
   logic                pfx_announced;
   logic [4:0]          stb_vec;

   // prefixes are never delivered here, so an announced prefix is missing.
   assign pfx_announced =
      (beat_data[fhp_pkg::xp10_pfx_lo_msb:fhp_pkg::xp10_pfx_lo_lsb] != '0) &&
      (beat_data[fhp_pkg::xp10_pfx_hi_msb:fhp_pkg::xp10_pfx_hi_lsb] != '0);

   // ****************************************
   // format decode
   // ****************************************
   always_comb begin
      fmt_nxt = fhp_pkg::fmt_none;
      err_nxt = fhp_pkg::err_no_errors;
      if (frm_coding == fhp_pkg::coding_raw) begin
         fmt_nxt = fhp_pkg::fmt_none;           // raw frames are not parsed.
      end else if (beat_data[31:0] == fhp_pkg::xp9_id) begin
         fmt_nxt = fhp_pkg::fmt_xp9;
      end else if (beat_data[31:0] == fhp_pkg::xp10_id) begin
         fmt_nxt = fhp_pkg::fmt_xp10;
         if (pfx_announced) begin
            err_nxt = fhp_pkg::err_pfx_data_absent;
         end
      end else if ((beat_data[7:0] == fhp_pkg::gzip_id1) &&
                   (beat_data[15:8] == fhp_pkg::gzip_id2)) begin
         fmt_nxt = fhp_pkg::fmt_gzip;
      end else if (beat_data[3:0] == fhp_pkg::zlib_cm) begin
         fmt_nxt = fhp_pkg::fmt_zlib;
      end else begin
         err_nxt = fhp_pkg::err_bad_format;
      end
   end

   // ****************************************
   // sof record and strobes
   // ****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sof_valid    <= 1'b0;
         sof_fmt      <= fhp_pkg::fmt_none;
         sof_error    <= fhp_pkg::err_no_errors;
         xp9_frm_stb  <= 1'b0;
         xp10_frm_stb <= 1'b0;
         raw_frm_stb  <= 1'b0;
         gzip_frm_stb <= 1'b0;
         zlib_frm_stb <= 1'b0;
      end else begin
         sof_valid <= first_data_beat;
         if (first_data_beat) begin
            sof_fmt   <= fmt_nxt;
            sof_error <= err_nxt;
         end else begin
            sof_fmt   <= fhp_pkg::fmt_none;
            sof_error <= fhp_pkg::err_no_errors;
         end
         xp9_frm_stb  <= sof_valid && (sof_fmt == fhp_pkg::fmt_xp9);
         xp10_frm_stb <= sof_valid && (sof_fmt == fhp_pkg::fmt_xp10);
         raw_frm_stb  <= sof_valid && (sof_fmt == fhp_pkg::fmt_none);  // raw or bad.
         gzip_frm_stb <= sof_valid && (sof_fmt == fhp_pkg::fmt_gzip);
         zlib_frm_stb <= sof_valid && (sof_fmt == fhp_pkg::fmt_zlib);
      end
   end

   always_ff @(posedge clk) begin
      if (first_data_beat) begin
         sof_frame_num <= frame_num;
      end
   end

   assign stb_vec = {xp9_frm_stb, xp10_frm_stb, raw_frm_stb, gzip_frm_stb, zlib_frm_stb};

   a_stb_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(stb_vec));

endmodule

// File: design/fhp_tlv_sequencer.sv
`timescale 1ns/1ps
// fhp TLV sequencer
// reads the user FIFO, follows each TLV with a state machine and captures
// the frame coding and the data header fields.
module fhp_tlv_sequencer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 usr_empty,
   input  fhp_pkg::tlv_data_t   usr_tlv_data,
   input  fhp_pkg::tlv_strb_t   usr_tlv_strb,
   input  logic                 usr_tlv_sot,
   input  logic                 usr_tlv_eot,
   input  fhp_pkg::tlv_type_e   usr_tlv_type,
   input  logic                 lfa_dp_ready,
   input  logic                 sof_valid,
   output logic                 usr_rd,
   output logic                 beat_valid,
   output fhp_pkg::tlv_data_t   beat_data,
   output fhp_pkg::tlv_strb_t   beat_strb,
   output logic                 beat_eot,
   output logic                 data_beat,
   output logic                 first_data_beat,
   output fhp_pkg::frm_coding_e frm_coding,
   output fhp_pkg::frame_num_t  frame_num
);

   fhp_pkg::seq_state_e state;
   logic [3:0]          frmd_loc;      // beat index of the coding word.
   logic [3:0]          frmd_cnt;
   logic                eot_rd_q;
   logic                first_pend;    // header seen, no data beat yet.
   logic                sot_rd;
   logic                in_data_rd;
   logic                data_type;

   // descriptors and headers never wait on the analyzer.
   assign usr_rd     = !usr_empty && (lfa_dp_ready || (state != fhp_pkg::st_data));
   assign sot_rd     = usr_rd && usr_tlv_sot;
   assign in_data_rd = usr_rd && !usr_tlv_sot && (state == fhp_pkg::st_data);
   assign data_type  = (usr_tlv_type == fhp_pkg::tlv_data) ||
                       (usr_tlv_type == fhp_pkg::tlv_data_unk);

   // ****************************************
   // TLV state machine
   // ****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= fhp_pkg::st_idle;
         frmd_loc <= '0;
         eot_rd_q <= 1'b0;
      end else begin
         eot_rd_q <= usr_rd && usr_tlv_eot;
         if (sot_rd) begin
            case (usr_tlv_type)
               fhp_pkg::tlv_frmd_int_app: begin
                  state    <= fhp_pkg::st_frmd;
                  frmd_loc <= fhp_pkg::frmd_app_loc;
               end
               fhp_pkg::tlv_frmd_int_sip: begin
                  state    <= fhp_pkg::st_frmd;
                  frmd_loc <= fhp_pkg::frmd_sip_loc;
               end
               fhp_pkg::tlv_data, fhp_pkg::tlv_data_unk: begin
                  state <= fhp_pkg::st_data;
               end
               default: begin
                  state <= fhp_pkg::st_skip;
               end
            endcase
         end else if (eot_rd_q && !usr_rd) begin
            state <= fhp_pkg::st_idle;
         end
      end
   end

   // descriptor coding word, kept until the frame that uses it is classified.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frmd_cnt   <= '0;
         frm_coding <= fhp_pkg::coding_parseable;
      end else begin
         if (sot_rd) begin
            frmd_cnt <= 4'd1;
         end else if (usr_rd && (state == fhp_pkg::st_frmd) && (frmd_cnt != 4'hf)) begin
            frmd_cnt <= frmd_cnt + 4'd1;
         end
         if (usr_rd && !usr_tlv_sot && (state == fhp_pkg::st_frmd) &&
             (frmd_cnt == frmd_loc)) begin
            frm_coding <= fhp_pkg::frm_coding_e'(usr_tlv_data[fhp_pkg::coding_lsb +: 2]);
         end else if (sof_valid) begin
            frm_coding <= fhp_pkg::coding_parseable;
         end
      end
   end

   // ****************************************
   // beat register
   // ****************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_valid      <= 1'b0;
         data_beat       <= 1'b0;
         first_data_beat <= 1'b0;
         first_pend      <= 1'b0;
      end else begin
         beat_valid      <= usr_rd;
         data_beat       <= in_data_rd;
         first_data_beat <= in_data_rd && first_pend;
         if (sot_rd) begin
            first_pend <= data_type;
         end else if (in_data_rd) begin
            first_pend <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (usr_rd) begin
         beat_data <= usr_tlv_data;
         beat_strb <= usr_tlv_strb;
         beat_eot  <= usr_tlv_eot;
      end
      if (sot_rd && data_type) begin
         frame_num <= usr_tlv_data[fhp_pkg::hdr_frame_num_lsb +: $bits(fhp_pkg::frame_num_t)];
      end
   end

   // the read strobe must stay off an empty FIFO.
   a_no_rd_on_empty: assert property (@(posedge clk) disable iff (!rst_n)
      !(usr_rd && usr_empty));

endmodule

// File: design/fhp_top.sv
`timescale 1ns/1ps
// fhp top level
// user-channel front end of the frame header parser.
module fhp_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  usr_empty,
   input  fhp_pkg::tlv_data_t    usr_tlv_data,
   input  fhp_pkg::tlv_strb_t    usr_tlv_strb,
   input  logic                  usr_tlv_sot,
   input  logic                  usr_tlv_eot,
   input  fhp_pkg::tlv_type_e    usr_tlv_type,
   input  logic                  lfa_dp_ready,
   output logic                  usr_rd,
   output logic                  dp_valid,
   output fhp_pkg::tlv_data_t    dp_data,
   output logic                  dp_sof,
   output logic                  dp_eof,
   output fhp_pkg::bytes_valid_t dp_bytes_valid,
   output fhp_pkg::frm_bytes_t   eof_frm_bytes,
   output logic                  sof_valid,
   output fhp_pkg::sof_fmt_e     sof_fmt,
   output fhp_pkg::fhp_error_e   sof_error,
   output fhp_pkg::frame_num_t   sof_frame_num,
   output logic                  xp9_frm_stb,
   output logic                  xp10_frm_stb,
   output logic                  raw_frm_stb,
   output logic                  gzip_frm_stb,
   output logic                  zlib_frm_stb
);

   logic                 beat_valid;
   fhp_pkg::tlv_data_t   beat_data;
   fhp_pkg::tlv_strb_t   beat_strb;
   logic                 beat_eot;
   logic                 data_beat;
   logic                 first_data_beat;
   fhp_pkg::frm_coding_e frm_coding;
   fhp_pkg::frame_num_t  frame_num;

   fhp_tlv_sequencer i_seq (
      .clk             (clk),
      .rst_n           (rst_n),
      .usr_empty       (usr_empty),
      .usr_tlv_data    (usr_tlv_data),
      .usr_tlv_strb    (usr_tlv_strb),
      .usr_tlv_sot     (usr_tlv_sot),
      .usr_tlv_eot     (usr_tlv_eot),
      .usr_tlv_type    (usr_tlv_type),
      .lfa_dp_ready    (lfa_dp_ready),
      .sof_valid       (sof_valid),      // releases the captured coding.
      .usr_rd          (usr_rd),
      .beat_valid      (beat_valid),
      .beat_data       (beat_data),
      .beat_strb       (beat_strb),
      .beat_eot        (beat_eot),
      .data_beat       (data_beat),
      .first_data_beat (first_data_beat),
      .frm_coding      (frm_coding),
      .frame_num       (frame_num)
   );

   fhp_data_framer i_framer (
      .clk             (clk),
      .rst_n           (rst_n),
      .beat_valid      (beat_valid),
      .beat_data       (beat_data),
      .beat_strb       (beat_strb),
      .beat_eot        (beat_eot),
      .data_beat       (data_beat),
      .first_data_beat (first_data_beat),
      .dp_valid        (dp_valid),
      .dp_data         (dp_data),
      .dp_sof          (dp_sof),
      .dp_eof          (dp_eof),
      .dp_bytes_valid  (dp_bytes_valid),
      .eof_frm_bytes   (eof_frm_bytes)
   );

   fhp_sof_classifier i_classifier (
      .clk             (clk),
      .rst_n           (rst_n),
      .beat_data       (beat_data),
      .first_data_beat (first_data_beat),
      .frm_coding      (frm_coding),
      .frame_num       (frame_num),
      .sof_valid       (sof_valid),
      .sof_fmt         (sof_fmt),
      .sof_error       (sof_error),
      .sof_frame_num   (sof_frame_num),
      .xp9_frm_stb     (xp9_frm_stb),
      .xp10_frm_stb    (xp10_frm_stb),
      .raw_frm_stb     (raw_frm_stb),
      .gzip_frm_stb    (gzip_frm_stb),
      .zlib_frm_stb    (zlib_frm_stb)
   );

endmodule

// File: sim.f
design/fhp_pkg.sv
design/fhp_tlv_sequencer.sv
design/fhp_data_framer.sv
design/fhp_sof_classifier.sv
design/fhp_top.sv
verif/fhp_tb.sv

// File: verif/fhp_tb.sv
`timescale 1ns/1ps
// fhp testbench
// feeds TLV streams through a modelled user FIFO and scores the data, sof and strobe outputs.
module fhp_tb;

   typedef struct packed {
      fhp_pkg::tlv_type_e typ;
      logic               sot;
      logic               eot;
      fhp_pkg::tlv_strb_t strb;
      fhp_pkg::tlv_data_t data;
   } beat_rec_t;

   typedef struct packed {
      fhp_pkg::tlv_data_t    data;
      logic                  sof;
      logic                  eof;
      fhp_pkg::bytes_valid_t bv;
      fhp_pkg::frm_bytes_t   bytes;
   } dp_rec_t;

   typedef struct packed {
      fhp_pkg::sof_fmt_e   fmt;
      fhp_pkg::fhp_error_e err;
      fhp_pkg::frame_num_t num;
   } sof_rec_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  usr_empty;
   fhp_pkg::tlv_data_t    usr_tlv_data;
   fhp_pkg::tlv_strb_t    usr_tlv_strb;
   logic                  usr_tlv_sot;
   logic                  usr_tlv_eot;
   fhp_pkg::tlv_type_e    usr_tlv_type;
   logic                  lfa_dp_ready;
   logic                  usr_rd;
   logic                  dp_valid;
   fhp_pkg::tlv_data_t    dp_data;
   logic                  dp_sof;
   logic                  dp_eof;
   fhp_pkg::bytes_valid_t dp_bytes_valid;
   fhp_pkg::frm_bytes_t   eof_frm_bytes;
   logic                  sof_valid;
   fhp_pkg::sof_fmt_e     sof_fmt;
   fhp_pkg::fhp_error_e   sof_error;
   fhp_pkg::frame_num_t   sof_frame_num;
   logic                  xp9_frm_stb;
   logic                  xp10_frm_stb;
   logic                  raw_frm_stb;
   logic                  gzip_frm_stb;
   logic                  zlib_frm_stb;

   beat_rec_t          fifo_q[$];      // user FIFO model.
   dp_rec_t            exp_dp[$];
   sof_rec_t           exp_sof[$];
   logic [4:0]         exp_stb[$];
   integer             seed = 37;
   int                 total_beats = 0;
   int                 cycles = 0;
   bit                 rand_mode = 1'b0;
   bit                 raw_next = 1'b0;  // a raw descriptor waits for its frame.
   bit                 took;
   bit                 gap;
   dp_rec_t            dp_exp;
   dp_rec_t            dp_got;
   sof_rec_t           sof_exp;
   sof_rec_t           sof_got;
   logic [4:0]         stb_vec;
   logic [4:0]         stb_exp;
   logic               sof_seen = 1'b0;
   fhp_pkg::tlv_data_t words[6];

   always #4 clk = ~clk;

   fhp_top i_dut (.*);

   task automatic end_with_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // expected record from the classification rules.
   function automatic sof_rec_t expect_sof(input fhp_pkg::tlv_data_t w, input bit raw);
      sof_rec_t r;
      r = '0;
      if (raw) begin
         r.fmt = fhp_pkg::fmt_none;
      end else if (w[31:0] == fhp_pkg::xp9_id) begin
         r.fmt = fhp_pkg::fmt_xp9;
      end else if (w[31:0] == fhp_pkg::xp10_id) begin
         r.fmt = fhp_pkg::fmt_xp10;
         if ((w[37:36] != 2'b00) && (w[43:38] != 6'b000000)) begin
            r.err = fhp_pkg::err_pfx_data_absent;
         end
      end else if (w[7:0] == 8'h1f && w[15:8] == 8'h8b) begin
         r.fmt = fhp_pkg::fmt_gzip;
      end else if (w[3:0] == 4'd8) begin
         r.fmt = fhp_pkg::fmt_zlib;
      end else begin
         r.fmt = fhp_pkg::fmt_none;
         r.err = fhp_pkg::err_bad_format;
      end
      return r;
   endfunction

   function automatic logic [4:0] stb_for_fmt(input fhp_pkg::sof_fmt_e fmt);
      case (fmt)
         fhp_pkg::fmt_xp9:  return 5'b10000;
         fhp_pkg::fmt_xp10: return 5'b01000;
         fhp_pkg::fmt_gzip: return 5'b00010;
         fhp_pkg::fmt_zlib: return 5'b00001;
         default:           return 5'b00100;  // raw or bad format.
      endcase
   endfunction

   task automatic push_beat(input fhp_pkg::tlv_type_e typ, input bit sot, input bit eot,
                            input fhp_pkg::tlv_strb_t strb, input fhp_pkg::tlv_data_t data);
      beat_rec_t b;
      b.typ  = typ;
      b.sot  = sot;
      b.eot  = eot;
      b.strb = strb;
      b.data = data;
      fifo_q.push_back(b);
      total_beats++;
   endtask

   // ****************************************
   // TLV builders
   // ****************************************
   task automatic send_frame(input fhp_pkg::tlv_data_t first_word, input int n,
                             input int last_len, input bit unk);
      fhp_pkg::tlv_type_e  typ;
      fhp_pkg::tlv_data_t  hdr;
      fhp_pkg::tlv_data_t  w;
      fhp_pkg::frame_num_t fnum;
      fhp_pkg::tlv_strb_t  strb;
      fhp_pkg::frm_bytes_t sum;
      dp_rec_t             rec;
      sof_rec_t            s;
      if (unk) begin
         typ = fhp_pkg::tlv_data_unk;
      end else begin
         typ = fhp_pkg::tlv_data;
      end
      fnum = fhp_pkg::frame_num_t'($random(seed));
      hdr  = {$random(seed), $random(seed)};
      hdr[fhp_pkg::hdr_frame_num_lsb +: 11] = fnum;
      push_beat(typ, 1'b1, 1'b0, 8'hff, hdr);
      sum = '0;
      for (int i = 0; i < n; i++) begin
         w    = (i == 0) ? first_word : {$random(seed), $random(seed)};
         strb = (i == n - 1) ? (8'hff >> (8 - last_len)) : 8'hff;
         push_beat(typ, 1'b0, i == n - 1, strb, w);
         sum       = sum + ((i == n - 1) ? last_len : 8);
         rec.data  = w;
         rec.sof   = (i == 0);
         rec.eof   = (i == n - 1);
         rec.bv    = (i == n - 1) ? fhp_pkg::bytes_valid_t'(last_len % 8) : '0;
         rec.bytes = rec.eof ? sum : '0;
         exp_dp.push_back(rec);
      end
      s     = expect_sof(first_word, raw_next);
      s.num = fnum;
      exp_sof.push_back(s);
      exp_stb.push_back(stb_for_fmt(s.fmt));
      raw_next = 1'b0;
   endtask

   // five-beat descriptor, coding word at beat 3 (app) or beat 1 (sip).
   task automatic send_frmd(input bit sip, input bit raw);
      fhp_pkg::tlv_data_t w;
      int                 loc;
      loc = sip ? 1 : 3;
      for (int i = 0; i < 5; i++) begin
         w = {$random(seed), $random(seed)};
         if (i == loc) begin
            w[fhp_pkg::coding_lsb +: 2] = raw ? 2'b01 : 2'b00;
         end
         if (sip) begin
            push_beat(fhp_pkg::tlv_frmd_int_sip, i == 0, i == 4, 8'hff, w);
         end else begin
            push_beat(fhp_pkg::tlv_frmd_int_app, i == 0, i == 4, 8'hff, w);
         end
      end
      raw_next = raw;
   endtask

   task automatic send_skip(input int n);
      for (int i = 0; i < n; i++) begin
         push_beat(fhp_pkg::tlv_other, i == 0, i == n - 1, 8'hff, {$random(seed), $random(seed)});
      end
   endtask

   task automatic wait_drained;
      while (fifo_q.size() != 0 || exp_dp.size() != 0 || exp_sof.size() != 0 ||
             exp_stb.size() != 0) begin
         @(negedge clk);
      end
   endtask

   // ****************************************
   // FIFO driver
   // ****************************************
   initial begin
      wait (rst_n);
      forever begin
         @(negedge clk);
         took = usr_rd;
         @(posedge clk);
         #1;
         if (took) begin
            void'(fifo_q.pop_front());
         end
         gap          = rand_mode && ($unsigned($random(seed)) % 4 == 0);
         lfa_dp_ready = rand_mode ? $random(seed) & 1 : 1'b1;
         if (fifo_q.size() == 0 || gap) begin
            usr_empty = 1'b1;
         end else begin
            usr_empty    = 1'b0;
            usr_tlv_data = fifo_q[0].data;
            usr_tlv_strb = fifo_q[0].strb;
            usr_tlv_sot  = fifo_q[0].sot;
            usr_tlv_eot  = fifo_q[0].eot;
            usr_tlv_type = fifo_q[0].typ;
         end
      end
   end

   // ****************************************
   // scoreboard
   // ****************************************
   always @(negedge clk) begin
      if (rst_n) begin
         stb_vec = {xp9_frm_stb, xp10_frm_stb, raw_frm_stb, gzip_frm_stb, zlib_frm_stb};
         if (dp_valid) begin
            assert (exp_dp.size() != 0) else end_with_failure("data beat seen with none expected");
            dp_exp = exp_dp.pop_front();
            dp_got = {dp_data, dp_sof, dp_eof, dp_bytes_valid, eof_frm_bytes};
            assert (dp_got == dp_exp) else end_with_failure($sformatf(
               "mismatch at %0t: dp beat got %h expected %h", $time, dp_got, dp_exp));
         end else begin
            assert (eof_frm_bytes == '0) else end_with_failure($sformatf(
               "mismatch at %0t: eof_frm_bytes %0d without dp_valid", $time, eof_frm_bytes));
         end
         assert ((stb_vec != 5'b0) == sof_seen) else end_with_failure($sformatf(
            "mismatch at %0t: strobes %b after sof_valid %0b", $time, stb_vec, sof_seen));
         if (stb_vec != 5'b0) begin
            stb_exp = exp_stb.pop_front();
            assert (stb_vec == stb_exp) else end_with_failure($sformatf(
               "mismatch at %0t: strobes %b expected %b", $time, stb_vec, stb_exp));
         end
         sof_seen = sof_valid;
         if (sof_valid) begin
            assert (exp_sof.size() != 0) else end_with_failure("sof record seen with none expected");
            sof_exp     = exp_sof.pop_front();
            sof_got.fmt = sof_fmt;
            sof_got.err = sof_error;
            sof_got.num = sof_frame_num;
            assert (sof_got == sof_exp) else end_with_failure($sformatf(
               "mismatch at %0t: sof got %h expected %h", $time, sof_got, sof_exp));
         end
      end
   end

   // budget grows with every beat pushed.
   initial begin
      forever begin
         @(negedge clk);
         cycles++;
         if (cycles > 200 + 16 * total_beats) begin
            end_with_failure($sformatf("watchdog expired after %0d cycles, outputs stalled",
                                       cycles));
         end
      end
   end

   // ****************************************
   // stimulus
   // ****************************************
   initial begin
      rst_n        = 1'b0;
      usr_empty    = 1'b1;
      usr_tlv_data = '0;
      usr_tlv_strb = '0;
      usr_tlv_sot  = 1'b0;
      usr_tlv_eot  = 1'b0;
      usr_tlv_type = fhp_pkg::tlv_other;
      lfa_dp_ready = 1'b1;
      words[0] = {32'h1234_5678, fhp_pkg::xp9_id};
      words[1] = {32'h0000_0010, fhp_pkg::xp10_id};   // one prefix field only.
      words[2] = {32'h0000_0050, fhp_pkg::xp10_id};   // both prefix fields.
      words[3] = 64'h0000_0000_0008_8b1f;
      words[4] = 64'h0000_0000_1234_9c78;
      words[5] = 64'h0000_0000_0000_00a5;

      for (int k = 0; k < 6; k++) begin
         send_frame(words[k], 3, 5, k == 4);
      end
      send_frmd(1'b0, 1'b1);
      send_frame(words[3], 2, 8, 1'b0);
      send_frame(words[3], 2, 8, 1'b0);
      send_skip(3);
      send_frmd(1'b1, 1'b1);
      send_frame(words[0], 1, 3, 1'b0);
      send_frame(words[0], 1, 3, 1'b0);
      for (int len = 1; len <= 8; len++) begin
         send_frame(words[4], 1 + len % 3, len, 1'b0);
      end

      repeat (9) @(posedge clk);
      @(negedge clk);
      assert (!usr_rd && !dp_valid && !sof_valid && !xp9_frm_stb && !xp10_frm_stb &&
              !raw_frm_stb && !gzip_frm_stb && !zlib_frm_stb) else
         end_with_failure("outputs were not idle during reset");
      @(posedge clk);
      #1;
      rst_n = 1'b1;
      wait_drained();

      rand_mode = 1'b1;
      repeat (24) begin
         if ($unsigned($random(seed)) % 4 == 0) begin
            send_frmd($random(seed) & 1, $random(seed) & 1);
         end
         send_frame(words[$unsigned($random(seed)) % 6], 1 + $unsigned($random(seed)) % 5,
                    1 + $unsigned($random(seed)) % 8, $random(seed) & 1);
      end
      wait_drained();
      repeat (10) @(negedge clk);
      $display("TEST PASSED");
      $finish;
   end

endmodule
